// File: hw/fifo_axil_pkg.sv
package fifo_axil_pkg;

  localparam int word_width = 32;
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;
  localparam int msg_words  = 4;

  typedef logic [word_width-1:0] word_t;
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [strb_width-1:0] strb_t;

  typedef enum logic [7:0] {
    e_mem_rd    = 8'h00,
    e_mem_wr    = 8'h01,
    e_mem_uc_rd = 8'h02,
    e_mem_uc_wr = 8'h03
  } mem_msg_e;

  // Encoded as log2 of the byte count
  typedef enum logic [7:0] {
    e_size_1 = 8'h00,
    e_size_2 = 8'h01,
    e_size_4 = 8'h02
  } msg_size_e;

  typedef struct packed {
    logic [7:0] did;
    logic [7:0] lce_id;
  } mem_payload_s;

  // Stream layout, lowest word goes out first
  typedef struct packed {
    logic [word_width-1:0] padding;
    data_t                 data;
    addr_t                 addr;
    mem_payload_s          payload;
    logic [7:0]            size;
    logic [7:0]            msg_type;
  } aligned_msg_s;

  typedef struct packed {
    mem_msg_e     msg_type;
    msg_size_e    size;
    addr_t        addr;
    mem_payload_s payload;
  } mem_header_s;

  typedef enum logic [2:0] {
    e_idle,
    e_wr_req,
    e_wr_resp,
    e_rd_req,
    e_rd_resp,
    e_send_rev
  } master_state_e;

endpackage

// File: hw/fifo_msg_deserializer.sv
module fifo_msg_deserializer (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  fifo_axil_pkg::word_t        word_i,
  input  logic                       word_v_i,
  output logic                       word_ready_and_o,

  output fifo_axil_pkg::aligned_msg_s msg_o,
  output logic                       msg_v_o,
  input  logic                       msg_ready_and_i
);

  localparam int cnt_width = $clog2(fifo_axil_pkg::msg_words);

  logic [cnt_width-1:0] cnt_q;
  logic                 full_q;
  logic                 word_fire;
  logic                 msg_fire;
  logic                 last_word;
  fifo_axil_pkg::aligned_msg_s shift_q;

  // A new word may enter while the held message leaves
  assign word_ready_and_o = ~full_q | msg_ready_and_i;
  assign word_fire        = word_v_i & word_ready_and_o;
  assign msg_fire         = msg_v_o & msg_ready_and_i;
  assign last_word        = (cnt_q == cnt_width'(fifo_axil_pkg::msg_words - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else begin
      if (word_fire) begin
        cnt_q <= last_word ? '0 : cnt_q + 1'b1;
      end
      if (word_fire && last_word) begin
        full_q <= 1'b1;
      end else if (msg_fire) begin
        full_q <= 1'b0;
      end
    end
  end

  // Words enter at the top so the first one ends up lowest
  always_ff @(posedge clk_i) begin
    if (word_fire) begin
      shift_q <= {word_i, shift_q[$bits(shift_q)-1:fifo_axil_pkg::word_width]};
    end
  end

  assign msg_o   = shift_q;
  assign msg_v_o = full_q;

endmodule

// File: hw/fifo_msg_serializer.sv
module fifo_msg_serializer (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  fifo_axil_pkg::aligned_msg_s msg_i,
  input  logic                       msg_v_i,
  output logic                       msg_ready_and_o,

  output fifo_axil_pkg::word_t        word_o,
  output logic                       word_v_o,
  input  logic                       word_ready_and_i
);

  localparam int cnt_width = $clog2(fifo_axil_pkg::msg_words);

  logic [cnt_width-1:0] cnt_q;
  logic                 busy_q;
  logic                 msg_fire;
  logic                 word_fire;
  fifo_axil_pkg::aligned_msg_s msg_q;

  assign msg_ready_and_o = ~busy_q;
  assign msg_fire        = msg_v_i & msg_ready_and_o;
  assign word_fire       = word_v_o & word_ready_and_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
    end else if (msg_fire) begin
      cnt_q  <= cnt_width'(fifo_axil_pkg::msg_words - 1);
      busy_q <= 1'b1;
    end else if (word_fire) begin
      cnt_q <= cnt_q - 1'b1;
      // Free after the last word
      if (cnt_q == '0) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (msg_fire) begin
      msg_q <= msg_i;
    end else if (word_fire) begin
      msg_q <= {fifo_axil_pkg::word_t'(0), msg_q[$bits(msg_q)-1:fifo_axil_pkg::word_width]};
    end
  end

  assign word_o   = msg_q[fifo_axil_pkg::word_width-1:0];
  assign word_v_o = busy_q;

endmodule

// File: hw/mem_axil_master.sv
module mem_axil_master (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  input  fifo_axil_pkg::mem_header_s fwd_header_i,
  input  fifo_axil_pkg::data_t       fwd_data_i,
  input  logic                      fwd_v_i,
  output logic                      fwd_ready_and_o,

  output fifo_axil_pkg::mem_header_s rev_header_o,
  output fifo_axil_pkg::data_t       rev_data_o,
  output logic                      rev_v_o,
  input  logic                      rev_ready_and_i,

  output fifo_axil_pkg::addr_t       m_axil_awaddr_o,
  output logic [2:0]                m_axil_awprot_o,
  output logic                      m_axil_awvalid_o,
  input  logic                      m_axil_awready_i,

  output fifo_axil_pkg::data_t       m_axil_wdata_o,
  output fifo_axil_pkg::strb_t       m_axil_wstrb_o,
  output logic                      m_axil_wvalid_o,
  input  logic                      m_axil_wready_i,

  input  logic [1:0]                m_axil_bresp_i,
  input  logic                      m_axil_bvalid_i,
  output logic                      m_axil_bready_o,

  output fifo_axil_pkg::addr_t       m_axil_araddr_o,
  output logic [2:0]                m_axil_arprot_o,
  output logic                      m_axil_arvalid_o,
  input  logic                      m_axil_arready_i,

  input  fifo_axil_pkg::data_t       m_axil_rdata_i,
  input  logic [1:0]                m_axil_rresp_i,
  input  logic                      m_axil_rvalid_i,
  output logic                      m_axil_rready_o
);

  fifo_axil_pkg::master_state_e state_q, state_d;
  fifo_axil_pkg::mem_header_s   header_q;
  fifo_axil_pkg::data_t         data_q;
  fifo_axil_pkg::strb_t         size_mask;

  logic aw_done_q, w_done_q;
  logic fwd_fire, fwd_is_wr;
  logic aw_fire, w_fire, wr_addr_data_done;

  assign fwd_ready_and_o = (state_q == fifo_axil_pkg::e_idle);
  assign fwd_fire        = fwd_v_i & fwd_ready_and_o;
  assign fwd_is_wr       = fwd_header_i.msg_type inside {fifo_axil_pkg::e_mem_wr,
                                                         fifo_axil_pkg::e_mem_uc_wr};

  assign aw_fire           = m_axil_awvalid_o & m_axil_awready_i;
  assign w_fire            = m_axil_wvalid_o & m_axil_wready_i;
  // aw and w may be accepted in either order
  assign wr_addr_data_done = (aw_done_q | aw_fire) & (w_done_q | w_fire);

  always_comb begin
    state_d = state_q;
    case (state_q)
      fifo_axil_pkg::e_idle:     if (fwd_fire) state_d = fwd_is_wr ? fifo_axil_pkg::e_wr_req
                                                                   : fifo_axil_pkg::e_rd_req;
      fifo_axil_pkg::e_wr_req:   if (wr_addr_data_done) state_d = fifo_axil_pkg::e_wr_resp;
      fifo_axil_pkg::e_wr_resp:  if (m_axil_bvalid_i) state_d = fifo_axil_pkg::e_send_rev;
      fifo_axil_pkg::e_rd_req:   if (m_axil_arready_i) state_d = fifo_axil_pkg::e_rd_resp;
      fifo_axil_pkg::e_rd_resp:  if (m_axil_rvalid_i) state_d = fifo_axil_pkg::e_send_rev;
      fifo_axil_pkg::e_send_rev: if (rev_ready_and_i) state_d = fifo_axil_pkg::e_idle;
      default:                   state_d = fifo_axil_pkg::e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= fifo_axil_pkg::e_idle;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if ((state_q == fifo_axil_pkg::e_wr_req) && !wr_addr_data_done) begin
        aw_done_q <= aw_done_q | aw_fire;
        w_done_q  <= w_done_q | w_fire;
      end else begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end
    end
  end

  // Read data replaces the request data for the response
  always_ff @(posedge clk_i) begin
    if (fwd_fire) begin
      header_q <= fwd_header_i;
      data_q   <= fwd_data_i;
    end else if ((state_q == fifo_axil_pkg::e_rd_resp) && m_axil_rvalid_i) begin
      data_q <= m_axil_rdata_i;
    end
  end

  always_comb begin
    case (header_q.size)
      fifo_axil_pkg::e_size_1: size_mask = fifo_axil_pkg::strb_t'(4'b0001);
      fifo_axil_pkg::e_size_2: size_mask = fifo_axil_pkg::strb_t'(4'b0011);
      default:                 size_mask = fifo_axil_pkg::strb_t'(4'b1111);
    endcase
  end

  assign m_axil_awaddr_o  = header_q.addr;
  assign m_axil_awprot_o  = 3'b000;
  assign m_axil_awvalid_o = (state_q == fifo_axil_pkg::e_wr_req) & ~aw_done_q;
  assign m_axil_wdata_o   = data_q;
  assign m_axil_wstrb_o   = size_mask << header_q.addr[1:0];
  assign m_axil_wvalid_o  = (state_q == fifo_axil_pkg::e_wr_req) & ~w_done_q;
  // bresp and rresp carry no information here, slave always answers OKAY
  assign m_axil_bready_o  = (state_q == fifo_axil_pkg::e_wr_resp);

  assign m_axil_araddr_o  = header_q.addr;
  assign m_axil_arprot_o  = 3'b000;
  assign m_axil_arvalid_o = (state_q == fifo_axil_pkg::e_rd_req);
  assign m_axil_rready_o  = (state_q == fifo_axil_pkg::e_rd_resp);

  assign rev_header_o = header_q;
  assign rev_data_o   = data_q;
  assign rev_v_o      = (state_q == fifo_axil_pkg::e_send_rev);

endmodule

// File: hw/fifo_to_axil_bridge.sv
module fifo_to_axil_bridge (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  fifo_axil_pkg::word_t  fifo_i,
  input  logic                 fifo_v_i,
  output logic                 fifo_ready_and_o,

  output fifo_axil_pkg::word_t  fifo_o,
  output logic                 fifo_v_o,
  input  logic                 fifo_ready_and_i,

  output fifo_axil_pkg::addr_t  m_axil_awaddr_o,
  output logic [2:0]           m_axil_awprot_o,
  output logic                 m_axil_awvalid_o,
  input  logic                 m_axil_awready_i,
  output fifo_axil_pkg::data_t  m_axil_wdata_o,
  output fifo_axil_pkg::strb_t  m_axil_wstrb_o,
  output logic                 m_axil_wvalid_o,
  input  logic                 m_axil_wready_i,
  input  logic [1:0]           m_axil_bresp_i,
  input  logic                 m_axil_bvalid_i,
  output logic                 m_axil_bready_o,
  output fifo_axil_pkg::addr_t  m_axil_araddr_o,
  output logic [2:0]           m_axil_arprot_o,
  output logic                 m_axil_arvalid_o,
  input  logic                 m_axil_arready_i,
  input  fifo_axil_pkg::data_t  m_axil_rdata_i,
  input  logic [1:0]           m_axil_rresp_i,
  input  logic                 m_axil_rvalid_i,
  output logic                 m_axil_rready_o
);

  fifo_axil_pkg::aligned_msg_s aligned_fwd, aligned_rev;
  logic aligned_fwd_v, aligned_fwd_ready_and;
  logic aligned_rev_v, aligned_rev_ready_and;

  fifo_axil_pkg::mem_header_s mem_fwd_header, mem_rev_header;
  fifo_axil_pkg::data_t       mem_fwd_data, mem_rev_data;
  logic mem_fwd_v, mem_fwd_ready_and;
  logic mem_rev_v, mem_rev_ready_and;
  logic rev_is_read;

  fifo_msg_deserializer i_fifo_msg_deserializer (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .word_i           (fifo_i),
    .word_v_i         (fifo_v_i),
    .word_ready_and_o (fifo_ready_and_o),
    .msg_o            (aligned_fwd),
    .msg_v_o          (aligned_fwd_v),
    .msg_ready_and_i  (aligned_fwd_ready_and)
  );

  always_comb begin
    mem_fwd_header.msg_type = fifo_axil_pkg::mem_msg_e'(aligned_fwd.msg_type);
    mem_fwd_header.size     = fifo_axil_pkg::msg_size_e'(aligned_fwd.size);
    mem_fwd_header.addr     = aligned_fwd.addr;
    mem_fwd_header.payload  = aligned_fwd.payload;
  end
  assign mem_fwd_data          = aligned_fwd.data;
  assign mem_fwd_v             = aligned_fwd_v;
  assign aligned_fwd_ready_and = mem_fwd_ready_and;

  mem_axil_master i_mem_axil_master (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fwd_header_i    (mem_fwd_header),
    .fwd_data_i      (mem_fwd_data),
    .fwd_v_i         (mem_fwd_v),
    .fwd_ready_and_o (mem_fwd_ready_and),
    .rev_header_o    (mem_rev_header),
    .rev_data_o      (mem_rev_data),
    .rev_v_o         (mem_rev_v),
    .rev_ready_and_i (mem_rev_ready_and),
    .*
  );

  always_comb begin
    aligned_rev.padding  = '0;
    aligned_rev.data     = mem_rev_data;
    aligned_rev.addr     = mem_rev_header.addr;
    aligned_rev.payload  = mem_rev_header.payload;
    aligned_rev.size     = mem_rev_header.size;
    aligned_rev.msg_type = mem_rev_header.msg_type;
  end

  // Write acks are swallowed the cycle they appear
  assign rev_is_read       = mem_rev_header.msg_type inside {fifo_axil_pkg::e_mem_rd,
                                                             fifo_axil_pkg::e_mem_uc_rd};
  assign aligned_rev_v     = mem_rev_v & rev_is_read;
  assign mem_rev_ready_and = rev_is_read ? aligned_rev_ready_and : 1'b1;

  fifo_msg_serializer i_fifo_msg_serializer (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .msg_i            (aligned_rev),
    .msg_v_i          (aligned_rev_v),
    .msg_ready_and_o  (aligned_rev_ready_and),
    .word_o           (fifo_o),
    .word_v_o         (fifo_v_o),
    .word_ready_and_i (fifo_ready_and_i)
  );

endmodule

// File: bench/axil_mem_model.sv
module axil_mem_model (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Per-cycle stalls: aw, w, ar ready and response latency
  input  logic [3:0]           stall_i,

  input  fifo_axil_pkg::addr_t s_axil_awaddr_i,
  input  logic                 s_axil_awvalid_i,
  output logic                 s_axil_awready_o,
  input  fifo_axil_pkg::data_t s_axil_wdata_i,
  input  fifo_axil_pkg::strb_t s_axil_wstrb_i,
  input  logic                 s_axil_wvalid_i,
  output logic                 s_axil_wready_o,
  output logic [1:0]           s_axil_bresp_o,
  output logic                 s_axil_bvalid_o,
  input  logic                 s_axil_bready_i,
  input  fifo_axil_pkg::addr_t s_axil_araddr_i,
  input  logic                 s_axil_arvalid_i,
  output logic                 s_axil_arready_o,
  output fifo_axil_pkg::data_t s_axil_rdata_o,
  output logic [1:0]           s_axil_rresp_o,
  output logic                 s_axil_rvalid_o,
  input  logic                 s_axil_rready_i
);

  fifo_axil_pkg::data_t mem [256];
  fifo_axil_pkg::addr_t aw_addr_q;
  fifo_axil_pkg::addr_t ar_addr_q;
  fifo_axil_pkg::data_t w_data_q;
  fifo_axil_pkg::strb_t w_strb_q;
  logic                 aw_got_q;
  logic                 w_got_q;
  logic                 ar_got_q;

  assign s_axil_awready_o = ~aw_got_q & ~stall_i[0];
  assign s_axil_wready_o  = ~w_got_q & ~stall_i[1];
  assign s_axil_arready_o = ~ar_got_q & ~s_axil_rvalid_o & ~stall_i[2];
  assign s_axil_bresp_o   = 2'b00;
  assign s_axil_rresp_o   = 2'b00;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= '0;
      end
      aw_got_q        <= 1'b0;
      w_got_q         <= 1'b0;
      ar_got_q        <= 1'b0;
      s_axil_bvalid_o <= 1'b0;
      s_axil_rvalid_o <= 1'b0;
    end else begin
      if (s_axil_awvalid_i && s_axil_awready_o) begin
        aw_addr_q <= s_axil_awaddr_i;
        aw_got_q  <= 1'b1;
      end
      if (s_axil_wvalid_i && s_axil_wready_o) begin
        w_data_q <= s_axil_wdata_i;
        w_strb_q <= s_axil_wstrb_i;
        w_got_q  <= 1'b1;
      end
      // Write lands once address and data are both in
      if (aw_got_q && w_got_q && !s_axil_bvalid_o && !stall_i[3]) begin
        for (int b = 0; b < 4; b++) begin
          if (w_strb_q[b]) begin
            mem[aw_addr_q[9:2]][8*b +: 8] <= w_data_q[8*b +: 8];
          end
        end
        aw_got_q        <= 1'b0;
        w_got_q         <= 1'b0;
        s_axil_bvalid_o <= 1'b1;
      end else if (s_axil_bvalid_o && s_axil_bready_i) begin
        s_axil_bvalid_o <= 1'b0;
      end
      if (s_axil_arvalid_i && s_axil_arready_o) begin
        ar_addr_q <= s_axil_araddr_i;
        ar_got_q  <= 1'b1;
      end
      if (ar_got_q && !s_axil_rvalid_o && !stall_i[3]) begin
        s_axil_rdata_o  <= mem[ar_addr_q[9:2]];
        s_axil_rvalid_o <= 1'b1;
        ar_got_q        <= 1'b0;
      end else if (s_axil_rvalid_o && s_axil_rready_i) begin
        s_axil_rvalid_o <= 1'b0;
      end
    end
  end

endmodule

// File: bench/bridge_assertions.sv
module bridge_assertions (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input fifo_axil_pkg::word_t fifo_o,
  input logic                 fifo_v_o,
  input logic                 fifo_ready_and_i,
  input fifo_axil_pkg::addr_t m_axil_awaddr_o,
  input logic                 m_axil_awvalid_o,
  input logic                 m_axil_awready_i,
  input fifo_axil_pkg::data_t m_axil_wdata_o,
  input logic                 m_axil_wvalid_o,
  input logic                 m_axil_wready_i,
  input fifo_axil_pkg::addr_t m_axil_araddr_o,
  input logic                 m_axil_arvalid_o,
  input logic                 m_axil_arready_i
);

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_axil_awvalid_o && !m_axil_awready_i |=> m_axil_awvalid_o && $stable(m_axil_awaddr_o))
    else $error("awvalid or awaddr changed before awready");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_axil_wvalid_o && !m_axil_wready_i |=> m_axil_wvalid_o && $stable(m_axil_wdata_o))
    else $error("wvalid or wdata changed before wready");

  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_axil_arvalid_o && !m_axil_arready_i |=> m_axil_arvalid_o && $stable(m_axil_araddr_o))
    else $error("arvalid or araddr changed before arready");

  out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fifo_v_o && !fifo_ready_and_i |=> fifo_v_o && $stable(fifo_o))
    else $error("output word changed while stalled");

  // One AXI transaction at a time
  rd_wr_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(m_axil_awvalid_o && m_axil_arvalid_o))
    else $error("awvalid and arvalid high together");

endmodule

bind fifo_to_axil_bridge bridge_assertions i_bridge_assertions (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .fifo_o           (fifo_o),
  .fifo_v_o         (fifo_v_o),
  .fifo_ready_and_i (fifo_ready_and_i),
  .m_axil_awaddr_o  (m_axil_awaddr_o),
  .m_axil_awvalid_o (m_axil_awvalid_o),
  .m_axil_awready_i (m_axil_awready_i),
  .m_axil_wdata_o   (m_axil_wdata_o),
  .m_axil_wvalid_o  (m_axil_wvalid_o),
  .m_axil_wready_i  (m_axil_wready_i),
  .m_axil_araddr_o  (m_axil_araddr_o),
  .m_axil_arvalid_o (m_axil_arvalid_o),
  .m_axil_arready_i (m_axil_arready_i)
);

// File: bench/bridge_tb.sv
module bridge_tb;

  localparam int max_tests      = 64;
  localparam int timeout_cycles = 1000;

  logic                 clk;
  logic                 rst_n;
  fifo_axil_pkg::word_t fifo_i;
  logic                 fifo_v_i;
  logic                 fifo_ready_and_o;
  fifo_axil_pkg::word_t fifo_o;
  logic                 fifo_v_o;
  logic                 fifo_ready_and_i = 1'b0;
  logic [3:0]           stall = 4'h0;
  logic [31:0]          lcg_state = 32'h0b18edbd;

  fifo_axil_pkg::addr_t awaddr, araddr;
  fifo_axil_pkg::data_t wdata, rdata;
  fifo_axil_pkg::strb_t wstrb;
  logic [2:0]           awprot, arprot;
  logic [1:0]           bresp, rresp;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;

  string                test_name    [max_tests];
  logic [7:0]           test_op      [max_tests];
  fifo_axil_pkg::addr_t test_addr    [max_tests];
  logic [7:0]           test_size    [max_tests];
  fifo_axil_pkg::data_t test_data    [max_tests];
  logic [15:0]          test_payload [max_tests];
  fifo_axil_pkg::data_t test_exp     [max_tests];
  int                   num_tests = 0;
  int                   read_order [$];
  int                   writes_sent = 0;
  bit                   run_aborted = 1'b0;

  fifo_axil_pkg::word_t exp_word;
  int word_idx = 0;
  int word_errors = 0;
  int reads_checked = 0;
  int failed_tests = 0;
  int wrong_words = 0;
  int stray_words = 0;
  int axi_idx = 0;
  int prot_errors = 0;

  fifo_to_axil_bridge i_fifo_to_axil_bridge (
    .clk_i (clk), .rst_n_i (rst_n),
    .fifo_i (fifo_i), .fifo_v_i (fifo_v_i), .fifo_ready_and_o (fifo_ready_and_o),
    .fifo_o (fifo_o), .fifo_v_o (fifo_v_o), .fifo_ready_and_i (fifo_ready_and_i),
    .m_axil_awaddr_o (awaddr), .m_axil_awprot_o (awprot),
    .m_axil_awvalid_o (awvalid), .m_axil_awready_i (awready),
    .m_axil_wdata_o (wdata), .m_axil_wstrb_o (wstrb),
    .m_axil_wvalid_o (wvalid), .m_axil_wready_i (wready),
    .m_axil_bresp_i (bresp), .m_axil_bvalid_i (bvalid), .m_axil_bready_o (bready),
    .m_axil_araddr_o (araddr), .m_axil_arprot_o (arprot),
    .m_axil_arvalid_o (arvalid), .m_axil_arready_i (arready),
    .m_axil_rdata_i (rdata), .m_axil_rresp_i (rresp),
    .m_axil_rvalid_i (rvalid), .m_axil_rready_o (rready)
  );

  axil_mem_model i_axil_mem_model (
    .clk_i (clk), .rst_n_i (rst_n), .stall_i (stall),
    .s_axil_awaddr_i (awaddr), .s_axil_awvalid_i (awvalid), .s_axil_awready_o (awready),
    .s_axil_wdata_i (wdata), .s_axil_wstrb_i (wstrb),
    .s_axil_wvalid_i (wvalid), .s_axil_wready_o (wready),
    .s_axil_bresp_o (bresp), .s_axil_bvalid_o (bvalid), .s_axil_bready_i (bready),
    .s_axil_araddr_i (araddr), .s_axil_arvalid_i (arvalid), .s_axil_arready_o (arready),
    .s_axil_rdata_o (rdata), .s_axil_rresp_o (rresp),
    .s_axil_rvalid_o (rvalid), .s_axil_rready_i (rready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic bit is_read(input logic [7:0] op);
    return (op == fifo_axil_pkg::e_mem_rd) || (op == fifo_axil_pkg::e_mem_uc_rd);
  endfunction

  // Stream word k of a request or of the expected response
  function automatic fifo_axil_pkg::word_t msg_word(input int idx, input int k, input bit rsp);
    case (k)
      0: return {test_payload[idx], test_size[idx], test_op[idx]};
      1: return test_addr[idx];
      2: return rsp ? test_exp[idx] : test_data[idx];
      default: return '0;
    endcase
  endfunction

  task automatic load_tests();
    int fd;
    int n;
    string line;
    string nm;
    logic [7:0] op;
    logic [7:0] sz;
    logic [15:0] pl;
    fifo_axil_pkg::addr_t ad;
    fifo_axil_pkg::data_t dt;
    fifo_axil_pkg::data_t ex;
    fd = $fopen("bench/bridge_testdata.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd) && num_tests < max_tests) begin
      if ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %h %h %h %h %h %h", nm, op, ad, sz, dt, pl, ex);
        if (n == 7) begin
          test_name[num_tests]    = nm;
          test_op[num_tests]      = op;
          test_addr[num_tests]    = ad;
          test_size[num_tests]    = sz;
          test_data[num_tests]    = dt;
          test_payload[num_tests] = pl;
          test_exp[num_tests]     = ex;
          num_tests++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic send_test(input int idx);
    int cycles;
    for (int k = 0; k < fifo_axil_pkg::msg_words; k++) begin
      fifo_i   <= msg_word(idx, k, 1'b0);
      fifo_v_i <= 1'b1;
      cycles = 0;
      @(posedge clk);
      while (!fifo_ready_and_o && cycles < timeout_cycles) begin
        @(posedge clk);
        cycles++;
      end
      if (!fifo_ready_and_o) begin
        $display("Timeout: word %0d of test %s was not accepted within %0d cycles",
                 k, test_name[idx], timeout_cycles);
        run_aborted = 1'b1;
        return;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Random output back-pressure and slave stalls
  always @(posedge clk) begin
    lcg_state = lcg_next(lcg_state);
    fifo_ready_and_i <= (lcg_state[17:16] != 2'b00);
    stall <= {lcg_state[31:30] == 2'b00, lcg_state[29:28] == 2'b00,
              lcg_state[27:26] == 2'b00, lcg_state[25:24] == 2'b00};
  end

  // One AXI address handshake per message, in send order
  always @(posedge clk) begin
    if (rst_n && awvalid) begin
      assert (awprot == 3'b000) else begin
        $display("Error: test %s awprot expected %h actual %h",
                 test_name[axi_idx], 3'b000, awprot);
        prot_errors++;
      end
    end
    if (rst_n && arvalid) begin
      assert (arprot == 3'b000) else begin
        $display("Error: test %s arprot expected %h actual %h",
                 test_name[axi_idx], 3'b000, arprot);
        prot_errors++;
      end
    end
    if (rst_n && ((awvalid && awready) || (arvalid && arready))) begin
      axi_idx++;
    end
  end

  always @(posedge clk) begin
    if (rst_n && fifo_v_o && fifo_ready_and_i) begin
      assert (reads_checked < read_order.size()) else begin
        $display("Output word %h arrived with no read outstanding", fifo_o);
        stray_words++;
      end
      if (reads_checked < read_order.size()) begin
        exp_word = msg_word(read_order[reads_checked], word_idx, 1'b1);
        assert (fifo_o == exp_word) else begin
          $display("Error: test %s word %0d expected %h actual %h",
                   test_name[read_order[reads_checked]], word_idx, exp_word, fifo_o);
          word_errors++;
        end
        if (word_idx == fifo_axil_pkg::msg_words - 1) begin
          if (word_errors == 0) begin
            $display("test %s: ok", test_name[read_order[reads_checked]]);
          end else begin
            $display("test %s: FAILED, %0d wrong words",
                     test_name[read_order[reads_checked]], word_errors);
            failed_tests++;
          end
          wrong_words += word_errors;
          word_errors = 0;
          word_idx = 0;
          reads_checked++;
        end else begin
          word_idx++;
        end
      end
    end
  end

  initial begin
    int cycles;
    rst_n    = 1'b0;
    fifo_i   = '0;
    fifo_v_i = 1'b0;
    load_tests();
    if (num_tests == 0) begin
      $display("No tests could be read from bench/bridge_testdata.txt");
      run_aborted = 1'b1;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < num_tests && !run_aborted; i++) begin
      if (is_read(test_op[i])) begin
        read_order.push_back(i);
      end
      send_test(i);
      if (!run_aborted && !is_read(test_op[i])) begin
        $display("test %s: write sent", test_name[i]);
        writes_sent++;
      end
    end
    fifo_v_i <= 1'b0;
    cycles = 0;
    while (!run_aborted && reads_checked < read_order.size() && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!run_aborted && reads_checked < read_order.size()) begin
      $display("Timeout: %0d read responses did not arrive within %0d cycles",
               read_order.size() - reads_checked, timeout_cycles);
      run_aborted = 1'b1;
    end
    // Idle time to catch stray words after the last read
    repeat (20) @(posedge clk);
    $display("%0d tests, %0d failed, %0d wrong words, %0d stray words, %0d prot errors",
             writes_sent + reads_checked, failed_tests, wrong_words, stray_words,
             prot_errors);
    if (!run_aborted && wrong_words == 0 && stray_words == 0 && prot_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: bench/bridge_testdata.txt
# name op addr size data payload expected_read (all but name in hex)
# op 00 rd, 01 wr, 02 uc_rd, 03 uc_wr; size 00 byte, 01 half, 02 word; data is lane-aligned
wr_word         01 00000010 02 deadbeef 0102 00000000
rd_word         00 00000010 02 00000000 0102 deadbeef
rd_unwritten    00 00000020 02 00000000 0304 00000000
wr_byte0        03 00000040 00 112233aa 0500 00000000
wr_byte1        03 00000041 00 4455bb66 0501 00000000
wr_byte2        03 00000042 00 77cc8899 0502 00000000
wr_byte3        03 00000043 00 ddeeff00 0503 00000000
rd_bytes        02 00000040 02 00000000 0504 ddccbbaa
wr_fill_a       01 00000100 02 11111111 0600 00000000
wr_half_hi      03 00000102 01 abcd1234 0601 00000000
rd_half_hi      02 00000100 02 00000000 0602 abcd1111
wr_fill_b       01 00000104 02 22222222 0700 00000000
wr_half_lo      03 00000104 01 ffff9abc 0701 00000000
rd_half_lo      00 00000104 01 00000000 0702 22229abc
wr_fill_c       01 00000108 02 33333333 0800 00000000
wr_byte_mid     03 0000010a 00 00ee0000 0801 00000000
rd_byte_mid     00 0000010a 00 00000000 0802 33ee3333
rd_word_again   00 00000010 02 00000000 0900 deadbeef
rd_unwritten_hi 02 000003fc 02 00000000 0901 00000000
wr_last         01 000003fc 02 cafef00d 0a00 00000000
rd_last         00 000003fc 02 00000000 0a01 cafef00d
rd_b2b_bytes    00 00000040 02 00000000 0b00 ddccbbaa
rd_b2b_half     02 00000104 02 00000000 0b01 22229abc
rd_b2b_last     00 000003fc 02 00000000 0b02 cafef00d

// File: all.f
hw/fifo_axil_pkg.sv
hw/fifo_msg_deserializer.sv
hw/fifo_msg_serializer.sv
hw/mem_axil_master.sv
hw/fifo_to_axil_bridge.sv
bench/axil_mem_model.sv
bench/bridge_assertions.sv
bench/bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --top-module bridge_tb -Mdir obj_dir -o bridge_sim -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/bridge_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$log"; then
  exit 1
fi
if ! grep -q "sim passed" "$log"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
